/* filelist.f */
hdl/cam_pkg.sv
hdl/cam_slice_ram.sv
hdl/cam_match_resolve.sv
hdl/cam.sv
verification/tb_cam.sv

/* hdl/cam.sv */
`timescale 1ns/1ps

module cam (
    input  logic                           clk,
    input  logic                           rst,

    // search strobe, result valid one cycle later
    input  logic                           start,

    // write strobe, key visible to searches from the next cycle
    input  logic                           write_enable,

    // key for both write and search
    input  logic [cam_pkg::DATA_WIDTH-1:0] din,

    // entry written when write_enable is high
    input  logic [cam_pkg::ADDR_WIDTH-1:0] write_addr,

    // search result, lowest matching address
    output logic                           match,
    output logic [cam_pkg::ADDR_WIDTH-1:0] match_addr
);

    // per-slice row vectors gathered for the resolver
    logic [cam_pkg::ENTRY_COUNT-1:0] slice_match [cam_pkg::SLICE_COUNT];

    // one table per key slice, slice k takes din bits from k*SLICE_WIDTH up
    for (genvar k = 0; k < cam_pkg::SLICE_COUNT; k++) begin : g_slice
        cam_slice_ram slice_ram_inst (
            .clk          (clk),
            .rst          (rst),
            .write_enable (write_enable),
            .write_addr   (write_addr),
            .slice_din    (din[k*cam_pkg::SLICE_WIDTH +: cam_pkg::SLICE_WIDTH]),
            .row_match    (slice_match[k])
        );
    end

    // combine slices and register the result
    cam_match_resolve match_resolve_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .slice_match (slice_match),
        .match       (match),
        .match_addr  (match_addr)
    );

endmodule

/* hdl/cam_match_resolve.sv */
`timescale 1ns/1ps

module cam_match_resolve (
    input  logic                            clk,
    input  logic                            rst,

    // search strobe, sampled at the rising edge
    input  logic                            start,

    // row vectors from every slice table
    input  logic [cam_pkg::ENTRY_COUNT-1:0] slice_match [cam_pkg::SLICE_COUNT],

    // held until the next start
    output logic                            match,
    output logic [cam_pkg::ADDR_WIDTH-1:0]  match_addr
);

    // entries that match in every slice
    logic [cam_pkg::ENTRY_COUNT-1:0] hit_vec;

    // priority encoder outputs
    logic                            any_hit;
    logic [cam_pkg::ADDR_WIDTH-1:0]  hit_idx;

    // and-reduce across slices
    always_comb begin
        hit_vec = '1;
        for (int k = 0; k < cam_pkg::SLICE_COUNT; k++) begin
            hit_vec = hit_vec & slice_match[k];
        end
    end

    // lowest set bit wins, so scan downward and let the last hit stand
    always_comb begin
        any_hit = 1'b0;
        hit_idx = '0;
        for (int i = cam_pkg::ENTRY_COUNT - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                any_hit = 1'b1;
                hit_idx = i[cam_pkg::ADDR_WIDTH-1:0];
            end
        end
    end

    // result register, updated only on start
    always_ff @(posedge clk) begin
        if (rst) begin
            match      <= 1'b0;
            match_addr <= '0;
        end else if (start) begin
            match      <= any_hit;
            // hit_idx is already 0 on a miss
            match_addr <= hit_idx;
        end
    end

endmodule

/* hdl/cam_pkg.sv */
package cam_pkg;

    // key width in bits, shared by write and search
    localparam int DATA_WIDTH = 32;

    // entry address width
    localparam int ADDR_WIDTH = 4;

    // one entry per address value
    localparam int ENTRY_COUNT = 1 << ADDR_WIDTH;

    // bits of the key handled by one slice table
    localparam int SLICE_WIDTH = 4;

    // slices needed to cover the key, rounded up
    localparam int SLICE_COUNT = (DATA_WIDTH + SLICE_WIDTH - 1) / SLICE_WIDTH;

    // one row per possible slice value
    localparam int SLICE_ROWS = 1 << SLICE_WIDTH;

    // each row is a bit vector with one bit per entry, so a slice table
    // holds SLICE_ROWS x ENTRY_COUNT bits; a search on a slice value
    // returns every entry whose stored slice equals it

endpackage

/* hdl/cam_slice_ram.sv */
`timescale 1ns/1ps

module cam_slice_ram (
    input  logic                           clk,
    input  logic                           rst,

    // write strobe, sampled at the rising edge
    input  logic                           write_enable,
    input  logic [cam_pkg::ADDR_WIDTH-1:0] write_addr,

    // slice of din, used for write and search alike
    input  logic [cam_pkg::SLICE_WIDTH-1:0] slice_din,

    // entries whose stored slice equals slice_din
    output logic [cam_pkg::ENTRY_COUNT-1:0] row_match
);

    // row r holds a bit per entry, set when that entry stores value r
    logic [cam_pkg::ENTRY_COUNT-1:0] rows [cam_pkg::SLICE_ROWS];

    // one-hot decode of the write address
    logic [cam_pkg::ENTRY_COUNT-1:0] addr_onehot;

    // one-hot decode of the slice value
    logic [cam_pkg::SLICE_ROWS-1:0]  row_sel;

    always_comb begin
        addr_onehot = '0;
        for (int i = 0; i < cam_pkg::ENTRY_COUNT; i++) begin
            if (i[cam_pkg::ADDR_WIDTH-1:0] == write_addr) begin
                addr_onehot[i] = 1'b1;
            end
        end
    end

    always_comb begin
        row_sel = '0;
        for (int r = 0; r < cam_pkg::SLICE_ROWS; r++) begin
            if (r[cam_pkg::SLICE_WIDTH-1:0] == slice_din) begin
                row_sel[r] = 1'b1;
            end
        end
    end

    // write clears the entry bit in every row, then sets it in the
    // selected row, so an overwrite drops the old key in one edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < cam_pkg::SLICE_ROWS; r++) begin
                rows[r] <= '0;
            end
        end else if (write_enable) begin
            for (int r = 0; r < cam_pkg::SLICE_ROWS; r++) begin
                if (row_sel[r]) begin
                    rows[r] <= rows[r] | addr_onehot;
                end else begin
                    rows[r] <= rows[r] & ~addr_onehot;
                end
            end
        end
    end

    // search read, combinational
    assign row_match = rows[slice_din];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CAM testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_cam
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

rm -f "$LOG"

verilator --binary --timing \
    -f filelist.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$TOP" 2>&1 | tee "$LOG"
sim_status=${PIPESTATUS[0]}

if [ ! -f "$LOG" ]; then
    echo "simulation log missing"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* verification/tb_cam.sv */
`timescale 1ns/1ps

module tb_cam;

    localparam int CLK_PERIOD  = 8;
    localparam int RESET_CYCLES = 5;
    // rough cycle budget of all tests together
    localparam int TEST_CYCLES = 120;
    localparam int MARGIN      = 4;

    logic                           clk;
    logic                           rst;
    logic                           start;
    logic                           write_enable;
    logic [cam_pkg::DATA_WIDTH-1:0] din;
    logic [cam_pkg::ADDR_WIDTH-1:0] write_addr;
    logic                           match;
    logic [cam_pkg::ADDR_WIDTH-1:0] match_addr;

    // reference model contents
    logic [cam_pkg::DATA_WIDTH-1:0] model_keys  [cam_pkg::ENTRY_COUNT];
    logic                           model_valid [cam_pkg::ENTRY_COUNT];

    // keys for back-to-back searches
    logic [cam_pkg::DATA_WIDTH-1:0] burst_keys  [cam_pkg::ENTRY_COUNT];

    integer seed = 32'hda00;

    cam UUT (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .write_enable (write_enable),
        .din          (din),
        .write_addr   (write_addr),
        .match        (match),
        .match_addr   (match_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%08h expected 0x%08h", name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // lowest valid address holding the key wins
    task automatic model_lookup(input logic [cam_pkg::DATA_WIDTH-1:0] key,
                                output logic exp_match,
                                output logic [cam_pkg::ADDR_WIDTH-1:0] exp_addr);
        exp_match = 1'b0;
        exp_addr  = '0;
        for (int i = 0; i < cam_pkg::ENTRY_COUNT; i++) begin
            if (!exp_match && model_valid[i] && model_keys[i] == key) begin
                exp_match = 1'b1;
                exp_addr  = i[cam_pkg::ADDR_WIDTH-1:0];
            end
        end
    endtask

    task automatic write_key(input logic [cam_pkg::ADDR_WIDTH-1:0] addr,
                             input logic [cam_pkg::DATA_WIDTH-1:0] key);
        @(posedge clk);
        write_enable <= 1'b1;
        write_addr   <= addr;
        din          <= key;
        start        <= 1'b0;
        @(posedge clk);
        write_enable <= 1'b0;
        model_keys[addr]  = key;
        model_valid[addr] = 1'b1;
    endtask

    task automatic search_check(input logic [cam_pkg::DATA_WIDTH-1:0] key);
        logic                           exp_match;
        logic [cam_pkg::ADDR_WIDTH-1:0] exp_addr;
        model_lookup(key, exp_match, exp_addr);
        @(posedge clk);
        start <= 1'b1;
        din   <= key;
        @(posedge clk);
        start <= 1'b0;
        // result registered on the edge above
        @(negedge clk);
        check_value("match", {31'b0, match}, {31'b0, exp_match});
        check_value("match_addr", {28'b0, match_addr}, {28'b0, exp_addr});
    endtask

    // one start per cycle with each result checked as it lands
    task automatic search_burst();
        logic                           exp_match [cam_pkg::ENTRY_COUNT];
        logic [cam_pkg::ADDR_WIDTH-1:0] exp_addr  [cam_pkg::ENTRY_COUNT];
        for (int i = 0; i < cam_pkg::ENTRY_COUNT; i++) begin
            model_lookup(burst_keys[i], exp_match[i], exp_addr[i]);
        end
        @(posedge clk);
        start <= 1'b1;
        din   <= burst_keys[0];
        for (int i = 0; i < cam_pkg::ENTRY_COUNT; i++) begin
            @(posedge clk);
            if (i < cam_pkg::ENTRY_COUNT - 1) begin
                din <= burst_keys[i + 1];
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            check_value("match", {31'b0, match}, {31'b0, exp_match[i]});
            check_value("match_addr", {28'b0, match_addr}, {28'b0, exp_addr[i]});
        end
    endtask

    task automatic reset_search_miss();
        search_check(32'h0000_0000);
        search_check(32'hffff_ffff);
        search_check(32'h1234_5678);
        search_check($random(seed));
    endtask

    task automatic single_write_hit();
        write_key(4'd5, 32'hcafe_0123);
        search_check(32'hcafe_0123);
        search_check(32'hcafe_0124);
    endtask

    task automatic overwrite_replaces_key();
        write_key(4'd5, 32'h0bad_f00d);
        search_check(32'hcafe_0123);
        search_check(32'h0bad_f00d);
    endtask

    task automatic lowest_address_wins();
        write_key(4'd9, 32'h5a5a_a5a5);
        write_key(4'd3, 32'h5a5a_a5a5);
        write_key(4'd12, 32'h5a5a_a5a5);
        search_check(32'h5a5a_a5a5);
        write_key(4'd3, 32'h0000_0003);
        search_check(32'h5a5a_a5a5);
    endtask

    task automatic random_fill_search();
        logic [cam_pkg::DATA_WIDTH-1:0] key;
        logic [cam_pkg::SLICE_WIDTH-1:0] delta;
        logic                            dup;
        int                              slice;
        for (int i = 0; i < cam_pkg::ENTRY_COUNT; i++) begin
            // draw again until the key is new among this batch
            do begin
                key = $random(seed);
                dup = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (burst_keys[j] == key) dup = 1'b1;
                end
            end while (dup);
            burst_keys[i] = key;
        end
        for (int i = 0; i < cam_pkg::ENTRY_COUNT; i++) begin
            write_key(i[cam_pkg::ADDR_WIDTH-1:0], burst_keys[i]);
        end
        search_burst();
        // flip one nonzero nibble per key
        for (int i = 0; i < cam_pkg::ENTRY_COUNT; i++) begin
            slice = i % cam_pkg::SLICE_COUNT;
            delta = 4'($random(seed));
            if (delta == 4'h0) delta = 4'h1;
            burst_keys[i] = burst_keys[i] ^ ({28'b0, delta} << (cam_pkg::SLICE_WIDTH * slice));
        end
        search_burst();
    endtask

    task automatic same_cycle_write_search();
        logic                           exp_match;
        logic [cam_pkg::ADDR_WIDTH-1:0] exp_addr;
        // expected from contents before the write lands
        model_lookup(32'h7777_1357, exp_match, exp_addr);
        @(posedge clk);
        write_enable <= 1'b1;
        write_addr   <= 4'd7;
        din          <= 32'h7777_1357;
        start        <= 1'b1;
        @(posedge clk);
        write_enable <= 1'b0;
        start        <= 1'b0;
        model_keys[7]  = 32'h7777_1357;
        model_valid[7] = 1'b1;
        @(negedge clk);
        check_value("match", {31'b0, match}, {31'b0, exp_match});
        check_value("match_addr", {28'b0, match_addr}, {28'b0, exp_addr});
        search_check(32'h7777_1357);
    endtask

    initial begin
        #(TEST_CYCLES * MARGIN * CLK_PERIOD);
        $display("timeout: tests did not finish within the expected time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        write_enable = 1'b0;
        din          = '0;
        write_addr   = '0;
        for (int i = 0; i < cam_pkg::ENTRY_COUNT; i++) begin
            model_keys[i]  = '0;
            model_valid[i] = 1'b0;
            burst_keys[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        reset_search_miss();
        single_write_hit();
        overwrite_replaces_key();
        lowest_address_wins();
        random_fill_search();
        same_cycle_write_search();

        $display("Result: PASSED");
        $finish;
    end

endmodule
